// File: Bender.yml
package:
  name: feed_ctrl

sources:
  # RTL, package first
  - hdl/feed_pkg.sv
  - hdl/ctrl_block_parser.sv
  - hdl/feed_word_assembler.sv
  - hdl/result_checker.sv
  - hdl/feed_sequencer.sv
  - hdl/feed_ctrl.sv
  # testbench
  - target: test
    files:
      - dv/sd_host_model.sv
      - dv/feed_tb.sv

// File: all.f
hdl/feed_pkg.sv
hdl/ctrl_block_parser.sv
hdl/feed_word_assembler.sv
hdl/result_checker.sv
hdl/feed_sequencer.sv
hdl/feed_ctrl.sv
dv/sd_host_model.sv
dv/feed_tb.sv

// File: dv/feed_tb.sv
// testbench for the test feeding controller
// three chained control blocks on a model SD card, a UUT stub that
// XORs the fed words, assertion checks and a watchdog

`timescale 1ns/1ps

module feed_tb;
  import feed_pkg::*;

  localparam int          WORD_SIZE   = 32;
  localparam int          INPUT_SIZE  = 64;
  localparam int          OUTPUT_SIZE = 32;
  localparam int          WORD_BYTES  = WORD_SIZE / 8;
  localparam logic [63:0] TIMEOUT     = 64'd2000;
  // two runs of three 512 byte block reads and two timeouts fit well inside
  localparam int          WATCHDOG_CYCLES = 200000;

  // control block field offsets
  localparam int NB_OFF = 4 + INPUT_SIZE / 8;
  localparam int TB_OFF = NB_OFF + 4;
  localparam int EX_OFF = TB_OFF + 8;

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic                   hang;
  logic                   spi_busy;
  logic [7:0]             spi_data;
  logic                   busy_uut;
  logic                   end_uut;
  logic                   err_uut;
  logic [OUTPUT_SIZE-1:0] uut_result;
  sd_req_t                sd_req;
  block_addr_t            spi_block_addr;
  uut_ctrl_t              uut_ctrl;
  logic [WORD_SIZE-1:0]   feed_word;
  logic [INPUT_SIZE-1:0]  uut_input;
  logic [31:0]            error_count;
  logic                   running;

  // image contents
  block_addr_t            cb_addr [3];
  logic [INPUT_SIZE-1:0]  tb_input [2];
  byte_cnt_t              total [2];
  logic [OUTPUT_SIZE-1:0] exp_result [2];

  // scoreboard
  logic [WORD_SIZE-1:0] exp_words [$];
  int   value_errors = 0;
  int   other_errors = 0;
  int   test_idx = 0;
  int   feeds_in_test = 0;
  int   block_reads = 0;
  int   multi_reads = 0;
  logic quiet = 1'b1;
  logic feed_prev = 1'b0;
  logic block_prev = 1'b0;
  logic multi_prev = 1'b0;

  // UUT stub state
  logic [WORD_SIZE-1:0] acc;
  logic [1:0]           busy_left;
  logic                 ending;

  feed_ctrl #(
    .WORD_SIZE     (WORD_SIZE),
    .INPUT_SIZE    (INPUT_SIZE),
    .OUTPUT_SIZE   (OUTPUT_SIZE),
    .TIMEOUT_CYCLES(TIMEOUT)
  ) dut0 (
    .clk             (clk),
    .rst             (rst),
    .start_i         (start),
    .spi_busy_i      (spi_busy),
    .spi_data_i      (spi_data),
    .busy_uut_i      (busy_uut),
    .end_uut_i       (end_uut),
    .err_uut_i       (err_uut),
    .uut_result_i    (uut_result),
    .sd_req_o        (sd_req),
    .spi_block_addr_o(spi_block_addr),
    .uut_ctrl_o      (uut_ctrl),
    .feed_word_o     (feed_word),
    .uut_input_o     (uut_input),
    .error_count_o   (error_count),
    .running_o       (running)
  );

  sd_host_model sd0 (
    .clk         (clk),
    .rst         (rst),
    .req_i       (sd_req),
    .block_addr_i(spi_block_addr),
    .busy_o      (spi_busy),
    .data_o      (spi_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // reporting and expected values
  task automatic log_mismatch(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    value_errors++;
    $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
  endtask

  task automatic note_failure(input string what);
    other_errors++;
    $display("failure at %0t: %s", $time, what);
  endtask

  function automatic logic [7:0] feed_byte(input int t, input int i);
    return 8'((t + 1) * 17 + i * 29);
  endfunction

  // big-endian word k of test t
  function automatic logic [WORD_SIZE-1:0] word_at(input int t, input int k);
    logic [WORD_SIZE-1:0] w;
    w = '0;
    for (int b = 0; b < WORD_BYTES; b++) begin
      w = {w[WORD_SIZE-9:0], feed_byte(t, k * WORD_BYTES + b)};
    end
    return w;
  endfunction

  task automatic put_control_block(input block_addr_t blk, input logic [31:0] id,
                                   input logic [INPUT_SIZE-1:0] in_vec,
                                   input block_addr_t next_blk, input byte_cnt_t count,
                                   input logic [OUTPUT_SIZE-1:0] want);
    for (int i = 0; i < 4; i++) sd0.load_byte(blk, i, id[8*(3-i) +: 8]);
    for (int i = 0; i < INPUT_SIZE / 8; i++) sd0.load_byte(blk, 4 + i, in_vec[8*i +: 8]);
    for (int i = 0; i < 4; i++) sd0.load_byte(blk, NB_OFF + i, next_blk[8*i +: 8]);
    for (int i = 0; i < 8; i++) sd0.load_byte(blk, TB_OFF + i, count[8*i +: 8]);
    for (int i = 0; i < OUTPUT_SIZE / 8; i++) sd0.load_byte(blk, EX_OFF + i, want[8*i +: 8]);
  endtask

  task automatic build_image();
    cb_addr[0]  = INITIAL_BLOCK;
    cb_addr[1]  = INITIAL_BLOCK + 32'h40;
    cb_addr[2]  = INITIAL_BLOCK + 32'h80;
    tb_input[0] = 64'h0123_4567_89AB_CDEF;
    tb_input[1] = 64'hFEDC_BA98_7654_3210;
    total[0]    = 64'd16;
    total[1]    = 64'd10;
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 24; i++) sd0.load_byte(cb_addr[t] + 32'd1, i, feed_byte(t, i));
      exp_result[t] = '0;
      for (int k = 0; k < total[t] / WORD_BYTES; k++) exp_result[t] ^= word_at(t, k);
    end
    // test two stores a wrong expected result
    exp_result[1] = exp_result[1] ^ 32'h0000_0100;
    put_control_block(cb_addr[0], CUT_ID, tb_input[0], cb_addr[1], total[0], exp_result[0]);
    put_control_block(cb_addr[1], CUT_ID, tb_input[1], cb_addr[2], total[1], exp_result[1]);
    put_control_block(cb_addr[2], 32'h1122_3344, '0, cb_addr[0], 64'd0, '0);
  endtask

  task automatic run_tests(input logic hang_mode, input logic [31:0] want_errors);
    exp_words.delete();
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < total[t] / WORD_BYTES; k++) exp_words.push_back(word_at(t, k));
    end
    test_idx      = 0;
    feeds_in_test = 0;
    block_reads   = 0;
    multi_reads   = 0;
    hang  <= hang_mode;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    quiet = 1'b0;
    @(negedge clk);
    while (running) @(negedge clk);
    quiet = 1'b1;
    assert (error_count == want_errors)
      else log_mismatch("error_count_o", error_count, want_errors);
    assert (block_reads == 3) else note_failure("control block reads do not number three");
    assert (multi_reads == 2) else note_failure("multi-block reads do not number two");
    assert (exp_words.size() == 0) else note_failure("some expected words were never fed");
    // the bad identifier ends the chain
    repeat (100) @(negedge clk);
    assert (block_reads == 3 && multi_reads == 2)
      else note_failure("SD reads went on after the bad identifier");
    @(posedge clk);
  endtask

  ////////////////////////////////////////
  // UUT stub
  initial begin
    busy_uut   = 1'b0;
    end_uut    = 1'b0;
    err_uut    = 1'b0;
    uut_result = '0;
    acc        = '0;
    busy_left  = '0;
    ending     = 1'b0;
    void'($urandom(68));
    forever begin
      @(posedge clk);
      if (rst || uut_ctrl.rst) begin
        busy_uut   <= 1'b0;
        end_uut    <= 1'b0;
        uut_result <= '0;
        acc        <= '0;
        busy_left  <= '0;
        ending     <= 1'b0;
      end else begin
        if (uut_ctrl.feed) begin
          acc       <= acc ^ feed_word;
          busy_uut  <= 1'b1;
          busy_left <= 2'($urandom % 4);
        end else if (busy_uut) begin
          if (busy_left == 0) busy_uut <= 1'b0;
          else busy_left <= busy_left - 2'd1;
        end
        // a hanging UUT never reports its end
        if (uut_ctrl.stop && !hang) ending <= 1'b1;
        if (ending) begin
          end_uut    <= 1'b1;
          uut_result <= acc;
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (quiet) begin
        assert (sd_req == '0) else log_mismatch("sd_req_o", sd_req, 0);
        assert (uut_ctrl == '0) else log_mismatch("uut_ctrl_o", uut_ctrl, 0);
        assert (!running) else log_mismatch("running_o", running, 0);
      end
      if (uut_ctrl.feed) begin
        assert (!busy_uut) else note_failure("feed pulse while the UUT was busy");
        assert (!feed_prev) else note_failure("feed pulse longer than one cycle");
        if (feeds_in_test == 0 && test_idx < 2) begin
          assert (uut_input == tb_input[test_idx])
            else log_mismatch("uut_input_o", uut_input, tb_input[test_idx]);
        end
        if (exp_words.size() == 0) begin
          note_failure("feed pulse with no word left to feed");
        end else begin
          assert (feed_word == exp_words[0])
            else log_mismatch("feed_word_o", feed_word, exp_words[0]);
          exp_words.delete(0);
        end
        feeds_in_test = feeds_in_test + 1;
      end
      if (uut_ctrl.stop) begin
        if (test_idx < 2) begin
          assert (feeds_in_test == total[test_idx] / WORD_BYTES)
            else log_mismatch("feed pulse count", feeds_in_test, total[test_idx] / WORD_BYTES);
        end
        test_idx      = test_idx + 1;
        feeds_in_test = 0;
      end
      if (sd_req.r_block && !block_prev) begin
        if (block_reads < 3) begin
          assert (spi_block_addr == cb_addr[block_reads])
            else log_mismatch("spi_block_addr_o", spi_block_addr, cb_addr[block_reads]);
        end
        block_reads = block_reads + 1;
      end
      if (sd_req.r_multi_block && !multi_prev) begin
        if (test_idx < 2) begin
          assert (spi_block_addr == cb_addr[test_idx] + 32'd1)
            else log_mismatch("spi_block_addr_o", spi_block_addr, cb_addr[test_idx] + 32'd1);
        end
        multi_reads = multi_reads + 1;
      end
    end
    feed_prev  = uut_ctrl.feed;
    block_prev = sd_req.r_block;
    multi_prev = sd_req.r_multi_block;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    other_errors++;
    $display("watchdog expired after %0d cycles, the DUT stopped making progress",
             WATCHDOG_CYCLES);
    $display("closing report: %0d wrong values, %0d other failures",
             value_errors, other_errors);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  initial begin
    rst   = 1'b1;
    start = 1'b0;
    hang  = 1'b0;
    build_image();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (20) @(posedge clk);
    // normal run, then a rerun with a hanging UUT
    run_tests(1'b0, 32'd1);
    run_tests(1'b1, 32'd2);
    $display("closing report: %0d wrong values, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : feed_tb

// File: dv/sd_host_model.sv
// SD card SPI host model
// serves bytes from a sparse block image, with busy handshakes for
// reset, single-block, multi-block and byte reads

`timescale 1ns/1ps

module sd_host_model #(
  parameter int SLOTS = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  feed_pkg::sd_req_t     req_i,
  input  feed_pkg::block_addr_t block_addr_i,
  output logic                  busy_o,
  output logic [7:0]            data_o
);
  import feed_pkg::*;

  typedef enum logic [1:0] {ACT_RST, ACT_OPEN, ACT_BYTE} act_e;

  // blocks without an image slot read back a fill pattern
  block_addr_t slot_blk [SLOTS];
  logic [7:0]  slot_mem [SLOTS*BLOCK_BYTES];
  int          n_slots = 0;

  act_e        act_q;
  logic        open_q;
  logic [1:0]  wait_q;
  logic [40:0] ptr_q;

  function automatic logic [7:0] fill_byte(input logic [40:0] addr);
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ addr[39:32]
         ^ {7'd0, addr[40]} ^ 8'h5A;
  endfunction

  function automatic logic [7:0] image_byte(input logic [40:0] addr);
    logic [7:0] b;
    b = fill_byte(addr);
    for (int s = 0; s < n_slots; s++) begin
      if (slot_blk[s] == addr[40:9]) b = slot_mem[s*BLOCK_BYTES + int'(addr[8:0])];
    end
    return b;
  endfunction

  task automatic load_byte(input block_addr_t blk, input int off, input logic [7:0] val);
    int slot;
    slot = -1;
    for (int s = 0; s < n_slots; s++) begin
      if (slot_blk[s] == blk) slot = s;
    end
    if (slot < 0 && n_slots < SLOTS) begin
      slot          = n_slots;
      slot_blk[slot] = blk;
      n_slots++;
      for (int i = 0; i < BLOCK_BYTES; i++) begin
        slot_mem[slot*BLOCK_BYTES + i] = fill_byte({blk, 9'(i)});
      end
    end
    if (slot >= 0) slot_mem[slot*BLOCK_BYTES + off] = val;
  endtask

  ////////////////////////////////////////
  // request handling
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o <= 1'b0;
      data_o <= '0;
      act_q  <= ACT_RST;
      open_q <= 1'b0;
      wait_q <= '0;
      ptr_q  <= '0;
    end else if (busy_o) begin
      if (wait_q != 0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        // data and the falling busy arrive together
        busy_o <= 1'b0;
        case (act_q)
          ACT_OPEN: open_q <= 1'b1;
          ACT_BYTE: begin
            data_o <= image_byte(ptr_q);
            ptr_q  <= ptr_q + 41'd1;
          end
          default: open_q <= 1'b0;
        endcase
      end
    end else if (req_i.rst) begin
      busy_o <= 1'b1;
      act_q  <= ACT_RST;
      wait_q <= 2'd3;
    end else if (req_i.r_byte && open_q) begin
      busy_o <= 1'b1;
      act_q  <= ACT_BYTE;
      wait_q <= ptr_q[1:0];
    end else if ((req_i.r_block || req_i.r_multi_block) && !open_q) begin
      busy_o <= 1'b1;
      act_q  <= ACT_OPEN;
      wait_q <= 2'd2;
      ptr_q  <= {block_addr_i, 9'd0};
    end else if (!req_i.r_block && !req_i.r_multi_block) begin
      open_q <= 1'b0;
    end
  end

endmodule : sd_host_model

// File: hdl/ctrl_block_parser.sv
// control block parser
// picks the control-block fields out of the SD byte stream by offset
// and checks the identifier against the circuit-under-test ID

`timescale 1ns/1ps

module ctrl_block_parser #(
  parameter int INPUT_SIZE  = 64,
  parameter int OUTPUT_SIZE = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear_i,
  input  logic                   byte_valid_i,
  input  logic [15:0]            byte_offset_i,
  input  logic [7:0]             byte_i,
  output logic                   id_ok_o,
  output logic [INPUT_SIZE-1:0]  uut_input_o,
  output feed_pkg::block_addr_t  next_block_o,
  output feed_pkg::byte_cnt_t    total_bytes_o,
  output logic [OUTPUT_SIZE-1:0] expected_o
);
  import feed_pkg::*;

  // field offsets inside the control block
  localparam int IN_BASE = ID_BYTES;
  localparam int NB_BASE = IN_BASE + INPUT_SIZE / 8;
  localparam int TB_BASE = NB_BASE + $bits(block_addr_t) / 8;
  localparam int EX_BASE = TB_BASE + $bits(byte_cnt_t) / 8;
  localparam int EX_END  = EX_BASE + OUTPUT_SIZE / 8;

  logic [8*ID_BYTES-1:0] id_q;

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      id_q          <= '0;
      uut_input_o   <= '0;
      next_block_o  <= '0;
      total_bytes_o <= '0;
      expected_o    <= '0;
    end else if (byte_valid_i) begin
      // identifier arrives msb first, everything else lsb first
      if (byte_offset_i < IN_BASE) begin
        id_q <= {id_q[8*ID_BYTES-9:0], byte_i};
      end else if (byte_offset_i < NB_BASE) begin
        uut_input_o[8*(byte_offset_i-IN_BASE) +: 8] <= byte_i;
      end else if (byte_offset_i < TB_BASE) begin
        next_block_o[8*(byte_offset_i-NB_BASE) +: 8] <= byte_i;
      end else if (byte_offset_i < EX_BASE) begin
        total_bytes_o[8*(byte_offset_i-TB_BASE) +: 8] <= byte_i;
      end else if (byte_offset_i < EX_END) begin
        expected_o[8*(byte_offset_i-EX_BASE) +: 8] <= byte_i;
      end
    end
  end

  assign id_ok_o = (id_q == CUT_ID);

endmodule : ctrl_block_parser

// File: hdl/feed_ctrl.sv
// test feeding controller
// reads test descriptions from an SD card through an SPI host, feeds
// the stored data to the unit under test and counts failing tests

`timescale 1ns/1ps

module feed_ctrl #(
  parameter int          WORD_SIZE      = 32,
  parameter int          INPUT_SIZE     = 64,
  parameter int          OUTPUT_SIZE    = 32,
  parameter logic [63:0] TIMEOUT_CYCLES = 64'h3000_0000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   spi_busy_i,
  input  logic [7:0]             spi_data_i,
  input  logic                   busy_uut_i,
  input  logic                   end_uut_i,
  input  logic                   err_uut_i,
  input  logic [OUTPUT_SIZE-1:0] uut_result_i,
  output feed_pkg::sd_req_t      sd_req_o,
  output feed_pkg::block_addr_t  spi_block_addr_o,
  output feed_pkg::uut_ctrl_t    uut_ctrl_o,
  output logic [WORD_SIZE-1:0]   feed_word_o,
  output logic [INPUT_SIZE-1:0]  uut_input_o,
  output logic [31:0]            error_count_o,
  output logic                   running_o
);
  import feed_pkg::*;

  logic                   id_ok;
  block_addr_t            next_block;
  byte_cnt_t              total_bytes;
  logic [OUTPUT_SIZE-1:0] expected;
  logic                   word_full;
  logic                   parse_valid;
  logic [15:0]            parse_offset;
  logic                   parse_clear;
  logic                   asm_valid;
  logic                   asm_clear;
  logic                   capture;
  logic                   compare;
  logic                   clear_count;

  ////////////////////////////////////////
  // control
  feed_sequencer #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_seq (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start_i),
    .spi_busy_i    (spi_busy_i),
    .busy_uut_i    (busy_uut_i),
    .end_uut_i     (end_uut_i),
    .err_uut_i     (err_uut_i),
    .id_ok_i       (id_ok),
    .next_block_i  (next_block),
    .total_bytes_i (total_bytes),
    .word_full_i   (word_full),
    .sd_req_o      (sd_req_o),
    .block_addr_o  (spi_block_addr_o),
    .uut_ctrl_o    (uut_ctrl_o),
    .parse_valid_o (parse_valid),
    .parse_offset_o(parse_offset),
    .parse_clear_o (parse_clear),
    .asm_valid_o   (asm_valid),
    .asm_clear_o   (asm_clear),
    .capture_o     (capture),
    .compare_o     (compare),
    .clear_count_o (clear_count),
    .running_o     (running_o)
  );

  ////////////////////////////////////////
  // datapath
  ctrl_block_parser #(
    .INPUT_SIZE (INPUT_SIZE),
    .OUTPUT_SIZE(OUTPUT_SIZE)
  ) u_parser (
    .clk          (clk),
    .rst          (rst),
    .clear_i      (parse_clear),
    .byte_valid_i (parse_valid),
    .byte_offset_i(parse_offset),
    .byte_i       (spi_data_i),
    .id_ok_o      (id_ok),
    .uut_input_o  (uut_input_o),
    .next_block_o (next_block),
    .total_bytes_o(total_bytes),
    .expected_o   (expected)
  );

  feed_word_assembler #(
    .WORD_SIZE(WORD_SIZE)
  ) u_asm (
    .clk         (clk),
    .rst         (rst),
    .clear_i     (asm_clear),
    .byte_valid_i(asm_valid),
    .byte_i      (spi_data_i),
    .word_o      (feed_word_o),
    .word_full_o (word_full)
  );

  result_checker #(
    .OUTPUT_SIZE(OUTPUT_SIZE)
  ) u_check (
    .clk          (clk),
    .rst          (rst),
    .clear_count_i(clear_count),
    .capture_i    (capture),
    .compare_i    (compare),
    .result_i     (uut_result_i),
    .expected_i   (expected),
    .err_uut_i    (err_uut_i),
    .error_count_o(error_count_o)
  );

endmodule : feed_ctrl

// File: hdl/feed_pkg.sv
// feed controller shared definitions
// SD block geometry, circuit-under-test identifier and the
// request/control bundles exchanged with the SPI host and the UUT

package feed_pkg;

  ////////////////////////////////////////
  // SD card geometry and test identity
  localparam int BLOCK_BYTES = 512;
  localparam int ID_BYTES    = 4;

  localparam logic [31:0] CUT_ID        = 32'hAABB_CCDD;
  localparam logic [31:0] INITIAL_BLOCK = 32'h0010_0000;

  ////////////////////////////////////////
  // scalar types
  typedef logic [31:0] block_addr_t;
  typedef logic [63:0] byte_cnt_t;

  ////////////////////////////////////////
  // request levels towards the SPI host
  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_multi_block;
    logic r_byte;
  } sd_req_t;

  // UUT controls
  // feed and stop are single-cycle pulses, rst is a level
  typedef struct packed {
    logic rst;
    logic feed;
    logic stop;
  } uut_ctrl_t;

endpackage : feed_pkg

// File: hdl/feed_sequencer.sv
// feed sequencer
// FSM that walks the SD card: control block read, ID check, multi-block
// feed towards the UUT, end of test or timeout, then the next block

`timescale 1ns/1ps

module feed_sequencer #(
  parameter logic [63:0] TIMEOUT_CYCLES = 64'h3000_0000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,
  input  logic                  spi_busy_i,
  input  logic                  busy_uut_i,
  input  logic                  end_uut_i,
  input  logic                  err_uut_i,
  input  logic                  id_ok_i,
  input  feed_pkg::block_addr_t next_block_i,
  input  feed_pkg::byte_cnt_t   total_bytes_i,
  input  logic                  word_full_i,
  output feed_pkg::sd_req_t     sd_req_o,
  output feed_pkg::block_addr_t block_addr_o,
  output feed_pkg::uut_ctrl_t   uut_ctrl_o,
  output logic                  parse_valid_o,
  output logic [15:0]           parse_offset_o,
  output logic                  parse_clear_o,
  output logic                  asm_valid_o,
  output logic                  asm_clear_o,
  output logic                  capture_o,
  output logic                  compare_o,
  output logic                  clear_count_o,
  output logic                  running_o
);
  import feed_pkg::*;

  typedef enum logic [4:0] {
    S_IDLE, S_SPI_RST, S_SPI_RST_WAIT,
    S_CB_SETUP, S_CB_REQ, S_CB_WAIT, S_CB_BYTE, S_CB_BYTE_WAIT, S_CHECK,
    S_FD_REQ, S_FD_WAIT, S_FD_BYTE, S_FD_BYTE_WAIT, S_FD_CHECK,
    S_FEED, S_UUT_HI, S_UUT_LO, S_STOP, S_WAIT_END, S_COMPARE, S_NEXT
  } state_e;

  state_e      state_q, state_d;
  block_addr_t cur_block_q;
  block_addr_t block_cnt_q;
  byte_cnt_t   byte_cnt_q;
  logic [63:0] timer_q;
  logic        timed_out;

  assign timed_out      = (timer_q > TIMEOUT_CYCLES);
  assign block_addr_o   = block_cnt_q;
  assign parse_offset_o = byte_cnt_q[15:0];
  assign running_o      = (state_q != S_IDLE);

  ////////////////////////////////////////
  // next state and strobes
  always_comb begin
    state_d       = state_q;
    sd_req_o      = '0;
    uut_ctrl_o    = '0;
    parse_valid_o = 1'b0;
    parse_clear_o = 1'b0;
    asm_valid_o   = 1'b0;
    asm_clear_o   = 1'b0;
    capture_o     = 1'b0;
    compare_o     = 1'b0;
    clear_count_o = 1'b0;

    case (state_q)
      S_IDLE: begin
        if (start_i) begin
          clear_count_o = 1'b1;
          state_d       = S_SPI_RST;
        end
      end
      S_SPI_RST: begin
        sd_req_o.rst   = 1'b1;
        uut_ctrl_o.rst = 1'b1;
        if (spi_busy_i) state_d = S_SPI_RST_WAIT;
      end
      S_SPI_RST_WAIT: begin
        uut_ctrl_o.rst = 1'b1;
        if (!spi_busy_i) state_d = S_CB_SETUP;
      end
      S_CB_SETUP: begin
        uut_ctrl_o.rst = 1'b1;
        parse_clear_o  = 1'b1;
        if (!spi_busy_i) state_d = S_CB_REQ;
      end
      S_CB_REQ, S_CB_WAIT: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        if (state_q == S_CB_REQ && spi_busy_i) state_d = S_CB_WAIT;
        if (state_q == S_CB_WAIT && !spi_busy_i) state_d = S_CB_BYTE;
      end
      S_CB_BYTE: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        sd_req_o.r_byte  = 1'b1;
        if (spi_busy_i) state_d = S_CB_BYTE_WAIT;
      end
      S_CB_BYTE_WAIT: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        if (!spi_busy_i) begin
          parse_valid_o = 1'b1;
          // the whole block is read, unused bytes included
          if (byte_cnt_q == byte_cnt_t'(BLOCK_BYTES - 1)) state_d = S_CHECK;
          else state_d = S_CB_BYTE;
        end
      end
      S_CHECK: begin
        uut_ctrl_o.rst = 1'b1;
        if (!id_ok_i) begin
          state_d = S_IDLE;
        end else if (!spi_busy_i) begin
          asm_clear_o = 1'b1;
          state_d     = S_FD_REQ;
        end
      end
      S_FD_REQ, S_FD_WAIT: begin
        sd_req_o.r_multi_block = 1'b1;
        if (state_q == S_FD_REQ && spi_busy_i) state_d = S_FD_WAIT;
        if (state_q == S_FD_WAIT && !spi_busy_i) state_d = S_FD_BYTE;
      end
      S_FD_BYTE: begin
        sd_req_o.r_multi_block = 1'b1;
        sd_req_o.r_byte        = 1'b1;
        if (spi_busy_i) state_d = S_FD_BYTE_WAIT;
      end
      S_FD_BYTE_WAIT: begin
        sd_req_o.r_multi_block = 1'b1;
        if (!spi_busy_i) begin
          asm_valid_o = 1'b1;
          state_d     = S_FD_CHECK;
        end
      end
      S_FD_CHECK: begin
        sd_req_o.r_multi_block = 1'b1;
        state_d = word_full_i ? S_FEED : S_FD_BYTE;
      end
      S_FEED: begin
        sd_req_o.r_multi_block = 1'b1;
        if (!busy_uut_i) begin
          // a partial last word is never fed
          if (byte_cnt_q > total_bytes_i) begin
            state_d = S_STOP;
          end else begin
            uut_ctrl_o.feed = 1'b1;
            asm_clear_o     = 1'b1;
            state_d         = S_UUT_HI;
          end
        end
      end
      S_UUT_HI: begin
        sd_req_o.r_multi_block = 1'b1;
        if (busy_uut_i) state_d = S_UUT_LO;
      end
      S_UUT_LO: begin
        sd_req_o.r_multi_block = 1'b1;
        if (!busy_uut_i) state_d = S_FD_BYTE;
      end
      S_STOP: begin
        uut_ctrl_o.stop = 1'b1;
        state_d         = S_WAIT_END;
      end
      S_WAIT_END: begin
        if (end_uut_i || err_uut_i || timed_out) begin
          capture_o = 1'b1;
          state_d   = S_COMPARE;
        end
      end
      S_COMPARE: begin
        compare_o = 1'b1;
        state_d   = S_NEXT;
      end
      S_NEXT: begin
        uut_ctrl_o.rst = 1'b1;
        state_d        = S_CB_SETUP;
      end
      default: state_d = S_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // state, block and byte counters, execution timer
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      cur_block_q <= INITIAL_BLOCK;
      block_cnt_q <= INITIAL_BLOCK;
      byte_cnt_q  <= '0;
      timer_q     <= '0;
    end else begin
      state_q <= state_d;
      timer_q <= timer_q + 64'd1;
      case (state_q)
        S_IDLE: begin
          if (start_i) cur_block_q <= INITIAL_BLOCK;
        end
        S_CB_SETUP: begin
          block_cnt_q <= cur_block_q;
          byte_cnt_q  <= '0;
        end
        S_CB_BYTE_WAIT, S_FD_BYTE_WAIT: begin
          if (!spi_busy_i) byte_cnt_q <= byte_cnt_q + 64'd1;
        end
        // feed data starts one block after the control block
        S_CHECK: begin
          block_cnt_q <= cur_block_q + 32'd1;
          byte_cnt_q  <= '0;
          timer_q     <= '0;
        end
        S_NEXT: cur_block_q <= next_block_i;
        default: ;
      endcase
    end
  end

endmodule : feed_sequencer

// File: hdl/feed_word_assembler.sv
// feed word assembler
// packs SD feed bytes into one UUT word, first byte most significant,
// and flags when a whole word has arrived since the last clear

`timescale 1ns/1ps

module feed_word_assembler #(
  parameter int WORD_SIZE = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear_i,
  input  logic                 byte_valid_i,
  input  logic [7:0]           byte_i,
  output logic [WORD_SIZE-1:0] word_o,
  output logic                 word_full_o
);

  localparam int WORD_BYTES = WORD_SIZE / 8;
  localparam int CNT_W      = $clog2(WORD_BYTES + 1);

  logic [WORD_SIZE-1:0] word_q;
  logic [CNT_W-1:0]     cnt_q;

  // big-endian shift in
  always_ff @(posedge clk) begin
    if (byte_valid_i) begin
      word_q <= (word_q << 8) | WORD_SIZE'(byte_i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      cnt_q <= '0;
    end else if (byte_valid_i && !word_full_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign word_full_o = (cnt_q == CNT_W'(WORD_BYTES));
  assign word_o      = word_q;

endmodule : feed_word_assembler

// File: hdl/result_checker.sv
// result checker
// latches the UUT result at the end of a test, compares it with the
// expected value and counts failed tests

`timescale 1ns/1ps

module result_checker #(
  parameter int OUTPUT_SIZE = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear_count_i,
  input  logic                   capture_i,
  input  logic                   compare_i,
  input  logic [OUTPUT_SIZE-1:0] result_i,
  input  logic [OUTPUT_SIZE-1:0] expected_i,
  input  logic                   err_uut_i,
  output logic [31:0]            error_count_o
);

  logic [OUTPUT_SIZE-1:0] result_q;
  logic                   err_q;
  logic [31:0]            count_q;
  logic                   fail;

  // err is taken together with the result, it may drop afterwards
  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= result_i;
      err_q    <= err_uut_i;
    end
  end

  assign fail = (result_q != expected_i) || err_q;

  always_ff @(posedge clk) begin
    if (rst || clear_count_i) begin
      count_q <= '0;
    end else if (compare_i && fail) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign error_count_o = count_q;

endmodule : result_checker
